// ==== hw/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ====================================================================
// datapath widths
// ====================================================================

// byte address width of the fetch pc
`define FETCH_AW 32
// full instruction word width
`define FETCH_IW 40
// instructions fetched per cycle
`define FETCH_SLOTS 2

// pc loaded by reset, also the power-on restart vector
`define FETCH_RSTPC 32'hFFFF_C000

// ====================================================================
// opcodes seen by predecode, in insn[5:0]
// ====================================================================

`define OP_WAI 6'h04
`define OP_RTS 6'h29
`define OP_BCC 6'h30
`define OP_JMP 6'h38

`endif

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// one instruction as delivered by the cache
	typedef struct packed {
		// raw 40-bit instruction word
		logic [39:0] insn;
		// byte length, 1 to 7
		logic [2:0]  len;
		// predictor says take, only meaningful for a branch
		logic        take;
	} fetch_slot_t;

	// everything fetched in one cycle
	typedef struct packed {
		// slot[0] is the older instruction
		fetch_slot_t [1:0] slot;
		// slot 0 valid
		logic              q1;
		// both slots valid
		logic              q2;
		// slot 0 blocked
		logic              q1bx;
	} fetch_bundle_t;

	// quick classification of one slot
	typedef struct packed {
		logic        is_wai;
		logic        is_rts;
		logic        is_br_taken;
		logic        is_jmp;
		// branch or jump destination, whichever the opcode selects
		logic [31:0] target;
	} predecode_t;

endpackage

`default_nettype wire

// ==== hw/redirect_pkg.sv ====
`default_nettype none

package redirect_pkg;

	// late redirect from the back end
	typedef struct packed {
		logic        branchmiss;
		logic [31:0] misspc;
	} miss_t;

	// config register write port
	typedef struct packed {
		logic        we;
		// 0 rstvec, 1 control, 2 restart
		logic [1:0]  addr;
		logic [31:0] wdata;
	} cfg_wr_t;

	// register outputs that steer the pc
	typedef struct packed {
		// one-cycle pulse, load rstvec
		logic        restart;
		// software freeze, holds pc like freezepc
		logic        freeze;
		// drop slot 1 from every bundle
		logic        single_issue;
		logic [31:0] rstvec;
	} fetch_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/insn_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module insn_predecode (
	input  wire logic [`FETCH_AW-1:0] pc,
	input  wire fetch_pkg::fetch_slot_t slot,
	// byte distance of this slot from pc
	input  wire logic [2:0] offset,
	output fetch_pkg::predecode_t pd
);

	logic [`FETCH_IW-1:0] insn;
	logic [5:0] opcode;
	logic [`FETCH_AW-1:0] disp;
	logic [`FETCH_AW-1:0] offset_ext;
	logic [`FETCH_AW-1:0] br_target;
	logic [`FETCH_AW-1:0] jmp_target;

	assign insn = slot.insn;
	assign opcode = insn[5:0];

	// ================================================================
	// target arithmetic
	// ================================================================

	// 17-bit displacement in insn[25:9], sign extended
	assign disp = {{(`FETCH_AW-17){insn[25]}}, insn[25:9]};
	assign offset_ext = {{(`FETCH_AW-3){1'b0}}, offset};

	// relative to the slot's own address, plus 2
	assign br_target = pc + offset_ext + disp + 2;

	// absolute jump address sits above the opcode
	assign jmp_target = insn[37:6];

	// ================================================================
	// opcode decode
	// ================================================================

	always_comb begin
		pd.is_wai = (opcode == `OP_WAI);
		pd.is_rts = (opcode == `OP_RTS);
		// a branch only redirects when the predictor takes it
		pd.is_br_taken = (opcode == `OP_BCC) && slot.take;
		pd.is_jmp = (opcode == `OP_JMP);
		// opcodes are exclusive so one target field is enough
		if (pd.is_jmp) begin
			pd.target = jmp_target;
		end else begin
			pd.target = br_target;
		end
	end

endmodule

`default_nettype wire

// ==== hw/branch_redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module branch_redirect (
	input  wire logic [`FETCH_AW-1:0] pc,
	// return address from the return stack
	input  wire logic [`FETCH_AW-1:0] ra,
	input  wire logic q1,
	input  wire logic q2,
	input  wire logic q1bx,
	input  wire logic [2:0] len0,
	input  wire fetch_pkg::predecode_t pd0,
	input  wire fetch_pkg::predecode_t pd1,
	output logic [`FETCH_AW-1:0] branch_pc,
	output logic pc_override
);

	logic [`FETCH_AW-1:0] len0_ext;
	logic s0_hit;
	logic s1_hit;
	logic [`FETCH_AW-1:0] s0_pc;
	logic [`FETCH_AW-1:0] s1_pc;

	assign len0_ext = {{(`FETCH_AW-3){1'b0}}, len0};

	assign s0_hit = pd0.is_wai | pd0.is_rts | pd0.is_br_taken | pd0.is_jmp;
	assign s1_hit = pd1.is_wai | pd1.is_rts | pd1.is_br_taken | pd1.is_jmp;

	// ================================================================
	// per-slot redirect address
	// ================================================================

	// slot 0 order: wai, rts, branch, jump
	always_comb begin
		if (pd0.is_wai) begin
			// wai spins on itself
			s0_pc = pc - 1;
		end else if (pd0.is_rts) begin
			s0_pc = ra;
		end else begin
			s0_pc = pd0.target;
		end
	end

	// slot 1 order: rts, wai, branch, jump
	always_comb begin
		if (pd1.is_rts) begin
			s1_pc = ra;
		end else if (pd1.is_wai) begin
			// slot 1 address is pc + len0
			s1_pc = pc + len0_ext - 1;
		end else begin
			s1_pc = pd1.target;
		end
	end

	// ================================================================
	// slot priority
	// ================================================================

	always_comb begin
		branch_pc = pc;
		if (q1 && !q1bx) begin
			// single valid slot, slot 1 not looked at
			if (s0_hit) begin
				branch_pc = s0_pc;
			end
		end else if (q2) begin
			// older slot wins
			if (s0_hit) begin
				branch_pc = s0_pc;
			end else if (s1_hit) begin
				branch_pc = s1_pc;
			end
		end
	end

	// any redirect shows up as a pc mismatch
	assign pc_override = (branch_pc != pc);

endmodule

`default_nettype wire

// ==== hw/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module program_counter (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic q1,
	// already masked by single_issue
	input  wire logic q2,
	input  wire logic q1bx,
	input  wire logic [2:0] len0,
	input  wire logic [2:0] len1,
	// external hold level
	input  wire logic freezepc,
	input  wire redirect_pkg::miss_t miss,
	input  wire redirect_pkg::fetch_ctrl_t ctrl,
	input  wire logic [`FETCH_AW-1:0] branch_pc,
	input  wire logic pc_override,
	output logic [`FETCH_AW-1:0] pc,
	output logic [`FETCH_AW-1:0] pcd,
	output logic pc_chg
);

	logic [`FETCH_AW-1:0] len0_ext;
	logic [`FETCH_AW-1:0] len1_ext;
	logic hold;

	assign len0_ext = {{(`FETCH_AW-3){1'b0}}, len0};
	assign len1_ext = {{(`FETCH_AW-3){1'b0}}, len1};

	// either freeze source stops sequential advance
	assign hold = freezepc | ctrl.freeze;

	// ================================================================
	// pc register
	// ================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `FETCH_RSTPC;
			pcd <= `FETCH_RSTPC;
		end else begin
			pcd <= pc;
			if (miss.branchmiss) begin
				// back end redirect beats everything
				pc <= miss.misspc;
			end else if (ctrl.restart) begin
				pc <= ctrl.rstvec;
			end else begin
				// sequential advance by fetched byte count
				if (!hold) begin
					if (q2) begin
						pc <= pc + len0_ext + len1_ext;
					end else if (q1 && !q1bx) begin
						pc <= pc + len0_ext;
					end
				end
				// early redirect replaces the advance, freeze or not
				if (pc_override) begin
					pc <= branch_pc;
				end
			end
		end
	end

	// high for the cycle after pc moved
	assign pc_chg = (pc != pcd);

endmodule

`default_nettype wire

// ==== hw/fetch_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_ctrl_regs (
	input  wire logic clk,
	input  wire logic rst,
	input  wire redirect_pkg::cfg_wr_t cfg,
	output logic [`FETCH_AW-1:0] cfg_rdata,
	output redirect_pkg::fetch_ctrl_t ctrl
);

	// write decode
	logic wr_vec;
	logic wr_ctl;
	logic wr_rst;

	assign wr_vec = cfg.we && (cfg.addr == 2'd0);
	assign wr_ctl = cfg.we && (cfg.addr == 2'd1);
	assign wr_rst = cfg.we && (cfg.addr == 2'd2);

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl.rstvec <= `FETCH_RSTPC;
			ctrl.freeze <= 1'b0;
			ctrl.single_issue <= 1'b0;
			ctrl.restart <= 1'b0;
		end else begin
			if (wr_vec) begin
				ctrl.rstvec <= cfg.wdata;
			end
			if (wr_ctl) begin
				ctrl.freeze <= cfg.wdata[0];
				ctrl.single_issue <= cfg.wdata[1];
			end
			// self-clearing, high for exactly one cycle per write
			ctrl.restart <= wr_rst;
		end
	end

	// read mux, restart address reads as zero
	always_comb begin
		case (cfg.addr)
			2'd0: cfg_rdata = ctrl.rstvec;
			2'd1: cfg_rdata = {{(`FETCH_AW-2){1'b0}}, ctrl.single_issue, ctrl.freeze};
			default: cfg_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/fetch_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit_top (
	input  wire logic clk,
	input  wire logic rst,
	input  wire fetch_pkg::fetch_bundle_t bundle,
	input  wire logic [`FETCH_AW-1:0] ra,
	input  wire redirect_pkg::miss_t miss,
	input  wire logic freezepc,
	input  wire redirect_pkg::cfg_wr_t cfg,
	output logic [`FETCH_AW-1:0] cfg_rdata,
	output logic [`FETCH_AW-1:0] pc,
	output logic [`FETCH_AW-1:0] pcd,
	output logic pc_chg,
	output logic [`FETCH_AW-1:0] branch_pc,
	output logic pc_override
);

	fetch_pkg::predecode_t pd [0:`FETCH_SLOTS-1];
	redirect_pkg::fetch_ctrl_t ctrl;
	// q2 as seen by the datapath
	logic q2_eff;

	assign q2_eff = bundle.q2 & ~ctrl.single_issue;

	// ================================================================
	// predecode, one per slot
	// ================================================================

	for (genvar i = 0; i < `FETCH_SLOTS; i++) begin : g_slot
		insn_predecode u_predecode (
			.pc     (pc),
			.slot   (bundle.slot[i]),
			// slot 1 sits len0 bytes past pc
			.offset ((i == 0) ? 3'd0 : bundle.slot[0].len),
			.pd     (pd[i])
		);
	end

	branch_redirect u_redirect (
		.pc          (pc),
		.ra          (ra),
		.q1          (bundle.q1),
		.q2          (q2_eff),
		.q1bx        (bundle.q1bx),
		.len0        (bundle.slot[0].len),
		.pd0         (pd[0]),
		.pd1         (pd[1]),
		.branch_pc   (branch_pc),
		.pc_override (pc_override)
	);

	program_counter u_pc (
		.clk         (clk),
		.rst         (rst),
		.q1          (bundle.q1),
		.q2          (q2_eff),
		.q1bx        (bundle.q1bx),
		.len0        (bundle.slot[0].len),
		.len1        (bundle.slot[1].len),
		.freezepc    (freezepc),
		.miss        (miss),
		.ctrl        (ctrl),
		.branch_pc   (branch_pc),
		.pc_override (pc_override),
		.pc          (pc),
		.pcd         (pcd),
		.pc_chg      (pc_chg)
	);

	fetch_ctrl_regs u_regs (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.cfg_rdata (cfg_rdata),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

// ==== tests/fetch_unit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit_checker (
	input wire logic clk,
	input wire logic rst,
	input wire logic freezepc,
	input wire redirect_pkg::miss_t miss,
	input wire redirect_pkg::fetch_ctrl_t ctrl,
	input wire logic pc_override,
	input wire logic [`FETCH_AW-1:0] pc,
	input wire logic pc_chg
);

	// ====================================================================
	// pc properties
	// ====================================================================

	// pc_chg flags exactly the cycle after a move
	a_pc_chg: assert property (@(posedge clk) disable iff (rst)
		pc_chg == (pc != $past(pc)))
		else $error("pc_chg disagrees with the change of pc");

	// back end miss wins on the next edge
	a_miss: assert property (@(posedge clk) disable iff (rst)
		miss.branchmiss |=> (pc == $past(miss.misspc)))
		else $error("branchmiss did not load misspc");

	// either freeze holds pc unless something redirects it
	a_freeze: assert property (@(posedge clk) disable iff (rst)
		((freezepc || ctrl.freeze) && !miss.branchmiss && !ctrl.restart && !pc_override)
		|=> (pc == $past(pc)))
		else $error("pc moved while frozen");

endmodule

bind program_counter fetch_unit_checker u_checker (
	.clk         (clk),
	.rst         (rst),
	.freezepc    (freezepc),
	.miss        (miss),
	.ctrl        (ctrl),
	.pc_override (pc_override),
	.pc          (pc),
	.pc_chg      (pc_chg)
);

`default_nettype wire

// ==== tests/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit_tb;

	// hex fields per vector line, see the header of the vector file
	localparam int NF = 18;
	localparam int MAX_VEC = 64;

	logic clk;
	logic rst;
	fetch_pkg::fetch_bundle_t bundle;
	logic [`FETCH_AW-1:0] ra;
	redirect_pkg::miss_t miss;
	logic freezepc;
	redirect_pkg::cfg_wr_t cfg;
	logic [`FETCH_AW-1:0] cfg_rdata;
	logic [`FETCH_AW-1:0] pc;
	logic [`FETCH_AW-1:0] pcd;
	logic pc_chg;
	logic [`FETCH_AW-1:0] branch_pc;
	logic pc_override;

	logic [39:0] vec_mem [0:NF*MAX_VEC-1];
	int n_vec = 0;
	logic loaded = 1'b0;

	fetch_unit_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.bundle      (bundle),
		.ra          (ra),
		.miss        (miss),
		.freezepc    (freezepc),
		.cfg         (cfg),
		.cfg_rdata   (cfg_rdata),
		.pc          (pc),
		.pcd         (pcd),
		.pc_chg      (pc_chg),
		.branch_pc   (branch_pc),
		.pc_override (pc_override)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ====================================================================
	// watchdog, scaled by the vector count once the file is loaded
	// ====================================================================

	initial begin
		wait (loaded);
		repeat (n_vec * 10 + 100) @(posedge clk);
		$display("Error at %0t: watchdog expired before all vectors were applied", $time);
		$display("Test failures found");
		$fatal(1, "timeout");
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
			$display("Test failures found");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// word left in memory where the vector file wrote nothing, tagged with its index
	function automatic logic [39:0] unfilled_word(input int idx);
		return {8'hFF, idx};
	endfunction

	// keeps the bits that the opcode gives a meaning, randomizes the rest
	function automatic logic [39:0] fill_unused(input logic [39:0] insn,
			input logic [39:0] rnd);
		logic [39:0] keep;
		case (insn[5:0])
			// displacement 25:9 and opcode
			`OP_BCC: keep = 40'h00_03FF_FE3F;
			// jump address 37:6 and opcode
			`OP_JMP: keep = 40'h3F_FFFF_FFFF;
			default: keep = 40'h00_0000_003F;
		endcase
		return (insn & keep) | (rnd & ~keep);
	endfunction

	// ====================================================================
	// main sequence
	// ====================================================================

	initial begin
		int b;
		logic [31:0] rnd_hi;
		logic [31:0] rnd_lo;
		logic [31:0] ra_now;
		logic [31:0] ra_prev;
		logic [31:0] exp_bpc;
		logic [31:0] exp_pc;
		// expected pc, pcd and pc_chg as seen after the last edge
		logic [31:0] pc_model;
		logic [31:0] pcd_model;
		logic chg_model;
		// expected config registers
		logic [31:0] rstvec_model;
		logic [1:0] ctl_model;
		logic [3:0] flags;
		fetch_pkg::fetch_bundle_t nb;
		redirect_pkg::miss_t nm;
		redirect_pkg::cfg_wr_t nc;

		void'($urandom(32'hce28));
		rst = 1'b1;
		bundle = '0;
		ra = '0;
		miss = '0;
		freezepc = 1'b0;
		cfg = '0;

		for (int i = 0; i < NF * MAX_VEC; i++) begin
			vec_mem[i] = unfilled_word(i);
		end
		$readmemh("tests/fetch_unit_tests.txt", vec_mem);
		while (n_vec < MAX_VEC && vec_mem[n_vec * NF] !== unfilled_word(n_vec * NF)) begin
			n_vec++;
		end
		if (n_vec == 0) begin
			$display("Error at %0t: no vectors read from tests/fetch_unit_tests.txt", $time);
			$display("Test failures found");
			$fatal(1, "empty vector file");
		end
		loaded = 1'b1;

		repeat (16) @(posedge clk);
		rst <= 1'b0;

		pc_model = `FETCH_RSTPC;
		pcd_model = `FETCH_RSTPC;
		chg_model = 1'b0;
		rstvec_model = `FETCH_RSTPC;
		ctl_model = 2'b00;
		ra_prev = '0;

		for (int v = 0; v < n_vec; v++) begin
			b = v * NF;
			rnd_hi = $urandom;
			rnd_lo = $urandom;
			nb.slot[0].insn = fill_unused(vec_mem[b], {rnd_hi[7:0], rnd_lo});
			nb.slot[0].len = vec_mem[b+1][2:0];
			nb.slot[0].take = vec_mem[b+2][0];
			rnd_hi = $urandom;
			rnd_lo = $urandom;
			nb.slot[1].insn = fill_unused(vec_mem[b+3], {rnd_hi[7:0], rnd_lo});
			nb.slot[1].len = vec_mem[b+4][2:0];
			nb.slot[1].take = vec_mem[b+5][0];
			nb.q1 = vec_mem[b+6][0];
			nb.q2 = vec_mem[b+7][0];
			nb.q1bx = vec_mem[b+8][0];
			nm.branchmiss = vec_mem[b+9][0];
			nm.misspc = vec_mem[b+10][31:0];
			nc.we = vec_mem[b+12][0];
			nc.addr = vec_mem[b+13][1:0];
			nc.wdata = vec_mem[b+14][31:0];
			ra_now = $urandom;

			@(posedge clk);
			bundle <= nb;
			ra <= ra_now;
			miss <= nm;
			freezepc <= vec_mem[b+11][0];
			cfg <= nc;

			@(negedge clk);
			// outcome of the previous vector
			check_value("pc", pc, pc_model);
			check_value("pcd", pcd, pcd_model);
			check_value("pc_chg", {31'd0, pc_chg}, {31'd0, chg_model});

			// flags pick ra as the expected value where the vector returns
			flags = vec_mem[b+17][3:0];
			exp_bpc = vec_mem[b+15][31:0];
			if (flags[0]) begin
				exp_bpc = ra_now;
			end
			if (flags[2]) begin
				// pc still holds the ra of the last return
				exp_bpc = ra_prev;
			end
			exp_pc = flags[1] ? ra_now : vec_mem[b+16][31:0];

			// redirect is combinational, visible in the same cycle
			check_value("branch_pc", branch_pc, exp_bpc);
			check_value("pc_override", {31'd0, pc_override}, {31'd0, exp_bpc != pc_model});

			// read port shows the registers as written up to the previous vector
			if (nc.addr == 2'd0) begin
				check_value("cfg_rdata", cfg_rdata, rstvec_model);
			end else if (nc.addr == 2'd1) begin
				check_value("cfg_rdata", cfg_rdata, {30'd0, ctl_model});
			end
			if (nc.we && nc.addr == 2'd0) begin
				rstvec_model = nc.wdata;
			end
			if (nc.we && nc.addr == 2'd1) begin
				ctl_model = nc.wdata[1:0];
			end

			chg_model = (exp_pc != pc_model);
			pcd_model = pc_model;
			pc_model = exp_pc;
			ra_prev = ra_now;
		end

		// one idle cycle to see the last vector land
		@(posedge clk);
		bundle <= '0;
		miss <= '0;
		freezepc <= 1'b0;
		cfg <= '0;
		@(negedge clk);
		check_value("pc", pc, pc_model);
		check_value("pcd", pcd, pcd_model);
		check_value("pc_chg", {31'd0, pc_chg}, {31'd0, chg_model});
		check_value("cfg_rdata", cfg_rdata, rstvec_model);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fetch_unit_tests.txt ====
// insn0 len0 take0 insn1 len1 take1 q1 q2 q1bx miss misspc freezepc we addr wdata
// exp_branch_pc exp_pc flags (bit0 bpc=ra, bit1 pc=ra, bit2 bpc=previous ra)
0000000001 4 0 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 FFFFC000 FFFFC004 0
0000000001 3 0 0000000001 5 0 1 1 0 0 00000000 0 0 0 00000000 FFFFC004 FFFFC00C 0
0000000001 4 0 0000000000 1 0 1 0 1 0 00000000 0 0 0 00000000 FFFFC00C FFFFC00C 0
0000000004 2 0 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 FFFFC00B FFFFC00B 0
0000000029 1 0 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 00000000 00000000 3
0000000000 1 0 0000000000 1 0 0 0 0 1 00001000 0 0 0 00000000 00000000 00001000 4
0000004030 3 1 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 00001022 00001022 0
0000004030 3 0 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 00001022 00001025 0
0000080038 5 0 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 00002000 00002000 0
0003FFE030 2 1 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 00001FF2 00001FF2 0
0000000001 3 0 0000000004 2 0 0 1 0 0 00000000 0 0 0 00000000 00001FF4 00001FF4 0
0000000001 4 0 0000008030 2 1 0 1 0 0 00000000 0 0 0 00000000 0000203A 0000203A 0
0000000001 4 0 0000008030 2 0 0 1 0 0 00000000 0 0 0 00000000 0000203A 00002040 0
0000000001 2 0 00000C0038 5 0 0 1 0 0 00000000 0 0 0 00000000 00003000 00003000 0
0000000001 1 0 0000000029 1 0 0 1 0 0 00000000 0 0 0 00000000 00000000 00000000 3
0000140038 3 0 0000000000 1 0 1 0 0 1 00004000 0 0 0 00000000 00005000 00004000 0
0000180038 2 0 0000000004 2 0 0 1 0 0 00000000 0 0 0 00000000 00006000 00006000 0
0000000001 3 0 0000000001 3 0 1 1 0 0 00000000 1 0 0 00000000 00006000 00006000 0
00001C0038 3 0 0000000000 1 0 1 0 0 0 00000000 1 0 0 00000000 00007000 00007000 0
0000000000 1 0 0000000000 1 0 0 0 0 0 00000000 0 1 1 00000001 00007000 00007000 0
0000000001 2 0 0000000001 4 0 1 1 0 0 00000000 0 0 0 00000000 00007000 00007000 0
0000000004 1 0 0000000000 1 0 1 0 0 0 00000000 0 0 0 00000000 00006FFF 00006FFF 0
0000000001 3 0 0000000000 1 0 1 0 0 1 00008000 0 0 0 00000000 00006FFF 00008000 0
0000000001 1 0 0000000001 1 0 1 1 0 0 00000000 0 1 1 00000002 00008000 00008000 0
0000000001 3 0 0000000001 4 0 1 1 0 0 00000000 0 0 0 00000000 00008000 00008003 0
0000000001 2 0 0000240038 2 0 0 1 0 0 00000000 0 0 0 00000000 00008003 00008003 0
0000000001 2 0 0000240038 2 0 1 1 0 0 00000000 0 0 0 00000000 00008003 00008005 0
0000000000 1 0 0000000000 1 0 0 0 0 0 00000000 0 1 1 00000000 00008005 00008005 0
0000000000 1 0 0000000000 1 0 0 0 0 0 00000000 0 1 0 0000A000 00008005 00008005 0
0000000000 1 0 0000000000 1 0 0 0 0 0 00000000 0 1 2 00000000 00008005 00008005 0
0000000000 1 0 0000000000 1 0 0 0 0 0 00000000 0 0 0 00000000 00008005 0000A000 0
0000000001 7 0 0000000001 7 0 1 1 0 0 00000000 0 0 0 00000000 0000A000 0000A00E 0
0000000000 1 0 0000000000 1 0 0 0 0 0 00000000 0 0 0 00000000 0000A00E 0000A00E 0

// ==== src.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/redirect_pkg.sv
hw/insn_predecode.sv
hw/branch_redirect.sv
hw/program_counter.sv
hw/fetch_ctrl_regs.sv
hw/fetch_unit_top.sv
tests/fetch_unit_checker.sv
tests/fetch_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)

sim: $(OBJ_DIR)/$(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
